// File: hw/digit_font.svh
// 8x8 bitmaps of the digits 0 to 9, included where score digits are drawn or modeled
localparam logic [0:9][0:7][7:0] DIGIT_FONT = {
    8'h3C, 8'h66, 8'h6E, 8'h7E, 8'h76, 8'h66, 8'h3C, 8'h00,
    8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h00,
    8'h3C, 8'h66, 8'h06, 8'h1C, 8'h30, 8'h66, 8'h7E, 8'h00,
    8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C, 8'h00,
    8'h0C, 8'h1C, 8'h2C, 8'h4C, 8'h7E, 8'h0C, 8'h0C, 8'h00,
    8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C, 8'h00,
    8'h3C, 8'h66, 8'h60, 8'h7C, 8'h66, 8'h66, 8'h3C, 8'h00,
    8'h7E, 8'h06, 8'h0C, 8'h18, 8'h30, 8'h30, 8'h30, 8'h00,
    8'h3C, 8'h66, 8'h66, 8'h3C, 8'h66, 8'h66, 8'h3C, 8'h00,
    8'h3C, 8'h66, 8'h66, 8'h3E, 8'h06, 8'h66, 8'h3C, 8'h00
};

// File: hw/video_pkg.sv
// VGA raster timing, pixel color type and scene palette for the game display
package video_pkg;

    localparam logic [10:0] H_ACTIVE = 11'd1280;
    localparam logic [10:0] H_FRONT  = 11'd32;
    localparam logic [10:0] H_SYNC   = 11'd192;
    localparam logic [10:0] H_BACK   = 11'd96;
    localparam logic [10:0] H_TOTAL  = 11'd1600;

    localparam logic [9:0] V_ACTIVE = 10'd480;
    localparam logic [9:0] V_FRONT  = 10'd10;
    localparam logic [9:0] V_SYNC   = 10'd2;
    localparam logic [9:0] V_BACK   = 10'd33;
    localparam logic [9:0] V_TOTAL  = 10'd525;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    localparam rgb_t SKY_COLOR         = '{8'd135, 8'd206, 8'd235};
    localparam rgb_t GROUND_LINE_COLOR = '{8'd0, 8'd0, 8'd0};
    localparam rgb_t DIRT_COLOR        = '{8'd139, 8'd69, 8'd19};
    localparam rgb_t DEEP_DIRT_COLOR   = '{8'd100, 8'd40, 8'd10};
    localparam rgb_t DIGIT_COLOR       = '{8'd0, 8'd0, 8'd0};
    localparam rgb_t CACTUS_COLOR      = '{8'd0, 8'd160, 8'd0};
    localparam rgb_t LAVA_COLOR        = '{8'd255, 8'd80, 8'd0};
    localparam rgb_t PTERO_COLOR       = '{8'd128, 8'd128, 8'd128};
    localparam rgb_t DINO_RUN_COLOR    = '{8'd80, 8'd80, 8'd80};
    localparam rgb_t DINO_DUCK_COLOR   = '{8'd0, 8'd0, 8'd200};
    localparam rgb_t DINO_JUMP_COLOR   = '{8'd200, 8'd0, 8'd200};
    localparam rgb_t BANNER_COLOR      = '{8'd255, 8'd0, 8'd0};

    typedef struct packed {
        logic [10:0] hcount;
        logic [9:0]  vcount;
    } raster_t;

endpackage

// File: hw/game_pkg.sv
// Game geometry, bus register map and the state structs passed between game blocks
package game_pkg;

    typedef logic [10:0] coord_t;

    localparam logic [8:0] ADDR_DINO_X = 9'd0;
    localparam logic [8:0] ADDR_DINO_Y = 9'd1;
    localparam logic [8:0] ADDR_DUCK   = 9'd13;
    localparam logic [8:0] ADDR_JUMP   = 9'd14;
    localparam logic [8:0] ADDR_REPLAY = 9'd19;

    localparam coord_t DINO_X_INIT   = 11'd100;
    localparam coord_t DINO_Y_INIT   = 11'd248;
    localparam coord_t SCAC_X_INIT   = 11'd1200;
    localparam coord_t GROUP_X_INIT  = 11'd1600;
    localparam coord_t LAVA_X_INIT   = 11'd1800;
    localparam coord_t PTERO_X_INIT  = 11'd1400;
    localparam coord_t GROUND_OBST_Y = 11'd248;
    localparam coord_t PTERO_Y       = 11'd200;

    // Box sizes in pixels
    localparam int BOX_SIZE    = 32;
    localparam int GROUP_WIDTH = 64;
    localparam int DIGIT_SIZE  = 8;
    localparam int BANNER_W    = 160;

    localparam coord_t GROUND_Y = 11'd280;
    localparam coord_t DIRT_Y   = 11'd300;
    localparam coord_t SCORE_X  = 11'd120;
    localparam coord_t SCORE_Y  = 11'd10;
    localparam coord_t BANNER_X = 11'd560;
    localparam coord_t BANNER_Y = 11'd200;

    localparam int N_DIGITS        = 5;
    localparam logic [5:0] LFSR_SEED = 6'b101011;
    localparam int PASSES_PER_STEP = 12;

    typedef struct packed {
        coord_t scac_x;
        coord_t group_x;
        coord_t lava_x;
        coord_t ptero_x;
    } obstacles_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   ducking;
        logic   jumping;
    } player_t;

    typedef logic [N_DIGITS-1:0][3:0] score_t;  // Digit 0 is units

endpackage

// File: hw/video_timing.sv
// Raster counters with VGA sync and blank, one pixel per clock
`timescale 1ns/1ps

module video_timing (
    input  logic               clk,
    input  logic               reset,
    output video_pkg::raster_t raster,
    output logic               vga_clk,
    output logic               vga_hs,
    output logic               vga_vs,
    output logic               vga_blank_n,
    output logic               vga_sync_n
);

    logic end_of_line;
    logic end_of_frame;

    assign end_of_line  = raster.hcount == video_pkg::H_TOTAL - 11'd1;
    assign end_of_frame = raster.vcount == video_pkg::V_TOTAL - 10'd1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            raster <= '0;
        end else begin
            raster.hcount <= end_of_line ? 11'd0 : raster.hcount + 11'd1;
            if (end_of_line) begin
                raster.vcount <= end_of_frame ? 10'd0 : raster.vcount + 10'd1;
            end
        end
    end

    assign vga_hs = !(raster.hcount >= video_pkg::H_ACTIVE + video_pkg::H_FRONT &&
        raster.hcount < video_pkg::H_ACTIVE + video_pkg::H_FRONT + video_pkg::H_SYNC);
    assign vga_vs = !(raster.vcount >= video_pkg::V_ACTIVE + video_pkg::V_FRONT &&
        raster.vcount < video_pkg::V_ACTIVE + video_pkg::V_FRONT + video_pkg::V_SYNC);
    assign vga_blank_n = raster.hcount < video_pkg::H_ACTIVE &&
        raster.vcount < video_pkg::V_ACTIVE;
    assign vga_sync_n = 1'b0;
    assign vga_clk    = raster.hcount[0];  // DAC strobe

endmodule

// File: hw/game_control.sv
// Bus register file, motion tick, collision test and game-over/replay control
`timescale 1ns/1ps

module game_control #(
    parameter int TICK_CYCLES = 2_000_000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  chipselect,
    input  logic                  write,
    input  logic [8:0]            address,
    input  logic [31:0]           writedata,
    input  game_pkg::obstacles_t  obstacles,
    output game_pkg::player_t     player,
    output logic                  tick,
    output logic                  restart,
    output logic                  game_over
);

    localparam int CNT_W = $clog2(TICK_CYCLES + 1);

    logic [CNT_W-1:0] tick_cnt;
    logic             cnt_wrap;
    logic             replay;
    logic             hit;

    // Half-open box test, the dino is always BOX_SIZE square
    function automatic logic overlap(input game_pkg::coord_t ax, ay, bx, by, input int bw);
        return (ax < bx + bw) && (ax + game_pkg::BOX_SIZE > bx) &&
               (ay < by + game_pkg::BOX_SIZE) && (ay + game_pkg::BOX_SIZE > by);
    endfunction

    assign hit =
        overlap(player.x, player.y, obstacles.scac_x, game_pkg::GROUND_OBST_Y,
                game_pkg::BOX_SIZE) ||
        overlap(player.x, player.y, obstacles.group_x, game_pkg::GROUND_OBST_Y,
                game_pkg::GROUP_WIDTH) ||
        overlap(player.x, player.y, obstacles.lava_x, game_pkg::GROUND_OBST_Y,
                game_pkg::BOX_SIZE) ||
        overlap(player.x, player.y, obstacles.ptero_x, game_pkg::PTERO_Y,
                game_pkg::BOX_SIZE);

    assign cnt_wrap = tick_cnt == CNT_W'(TICK_CYCLES - 1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            player <= '{x: game_pkg::DINO_X_INIT, y: game_pkg::DINO_Y_INIT,
                        ducking: 1'b0, jumping: 1'b0};
            replay <= 1'b0;
        end else if (chipselect && write) begin
            case (address)
                game_pkg::ADDR_DINO_X: player.x       <= writedata[10:0];
                game_pkg::ADDR_DINO_Y: player.y       <= writedata[10:0];
                game_pkg::ADDR_DUCK:   player.ducking <= writedata[0];
                game_pkg::ADDR_JUMP:   player.jumping <= writedata[0];
                game_pkg::ADDR_REPLAY: replay         <= writedata[0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_cnt  <= '0;
            tick      <= 1'b0;
            restart   <= 1'b0;
            game_over <= 1'b0;
        end else begin
            restart <= game_over && replay;
            tick    <= cnt_wrap && !game_over && !hit && !restart;
            if (restart) begin
                tick_cnt <= '0;
            end else if (!game_over) begin
                tick_cnt <= cnt_wrap ? '0 : tick_cnt + 1'b1;
            end
            if (game_over) begin
                if (replay) begin
                    game_over <= 1'b0;
                end
            end else if (hit && !restart) begin  // Obstacles still old on restart
                game_over <= 1'b1;
            end
        end
    end

endmodule

// File: hw/obstacle_track.sv
// Scrolls the four obstacles left each tick, wraps them and raises the speed
`timescale 1ns/1ps

module obstacle_track (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tick,
    input  logic                 restart,
    output game_pkg::obstacles_t obstacles
);

    localparam game_pkg::obstacles_t OBST_INIT = '{
        scac_x:  game_pkg::SCAC_X_INIT,
        group_x: game_pkg::GROUP_X_INIT,
        lava_x:  game_pkg::LAVA_X_INIT,
        ptero_x: game_pkg::PTERO_X_INIT
    };

    logic [5:0]       lfsr;
    game_pkg::coord_t speed;
    logic [3:0]       pass_cnt;
    logic             any_wrap;

    function automatic game_pkg::coord_t advance(input game_pkg::coord_t x,
                                                 input logic [9:0] offset);
        return (x <= speed) ? video_pkg::H_ACTIVE + {1'b0, offset} : x - speed;
    endfunction

    assign any_wrap = obstacles.scac_x <= speed || obstacles.group_x <= speed ||
                      obstacles.lava_x <= speed || obstacles.ptero_x <= speed;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            obstacles <= OBST_INIT;
            lfsr      <= game_pkg::LFSR_SEED;
            speed     <= 11'd1;
            pass_cnt  <= '0;
        end else if (restart) begin
            obstacles <= OBST_INIT;
            lfsr      <= game_pkg::LFSR_SEED;
            speed     <= 11'd1;
            pass_cnt  <= '0;
        end else if (tick) begin
            lfsr <= {lfsr[4:0], lfsr[5] ^ lfsr[4]};  // x^6 + x^5 + 1
            obstacles.scac_x  <= advance(obstacles.scac_x, {lfsr, 4'd0});
            obstacles.group_x <= advance(obstacles.group_x, {lfsr ^ 6'h3F, 4'd0});
            obstacles.lava_x  <= advance(obstacles.lava_x, {lfsr[3:0], 6'd0});
            obstacles.ptero_x <= advance(obstacles.ptero_x, {lfsr[5:2], 6'd0});
            if (any_wrap) begin
                if (pass_cnt == 4'(game_pkg::PASSES_PER_STEP - 1)) begin
                    pass_cnt <= '0;
                    speed    <= speed + 11'd1;
                end else begin
                    pass_cnt <= pass_cnt + 4'd1;
                end
            end
        end
    end

endmodule

// File: hw/score_counter.sv
// Five-digit decimal score, one step per motion tick
`timescale 1ns/1ps

module score_counter (
    input  logic             clk,
    input  logic             reset,
    input  logic             tick,
    input  logic             restart,
    output game_pkg::score_t score
);

    function automatic game_pkg::score_t bcd_inc(input game_pkg::score_t s);
        game_pkg::score_t r;
        logic             carry;
        r     = s;
        carry = 1'b1;
        for (int i = 0; i < game_pkg::N_DIGITS; i++) begin
            if (carry) begin
                if (s[i] == 4'd9) begin
                    r[i] = 4'd0;  // Ripple into next digit
                end else begin
                    r[i]  = s[i] + 4'd1;
                    carry = 1'b0;
                end
            end
        end
        return r;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            score <= '0;
        end else if (restart) begin
            score <= '0;
        end else if (tick) begin
            score <= bcd_inc(score);
        end
    end

endmodule

// File: hw/pixel_renderer.sv
// Composes each pixel from background, boxes, score and banner, one clock behind the raster
`timescale 1ns/1ps

module pixel_renderer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 game_over,
    input  video_pkg::raster_t   raster,
    input  game_pkg::player_t    player,
    input  game_pkg::obstacles_t obstacles,
    input  game_pkg::score_t     score,
    output video_pkg::rgb_t      color
);

    `include "digit_font.svh"

    video_pkg::rgb_t pixel;
    logic [10:0]     rx;
    logic [2:0]      ry;
    logic [2:0]      cx;
    logic [2:0]      slot;
    logic            in_score;
    logic [3:0]      digit;

    function automatic logic in_box(input logic [10:0] px, input logic [9:0] py,
                                    input game_pkg::coord_t x, y, input int w, ht);
        return px >= x && px < x + w && py >= y && py < y + ht;
    endfunction

    // Position inside the score field
    assign rx   = raster.hcount - game_pkg::SCORE_X;
    assign ry   = 3'(raster.vcount - game_pkg::SCORE_Y);
    assign cx   = 3'(rx % game_pkg::DIGIT_SIZE);
    assign slot = 3'(rx / game_pkg::DIGIT_SIZE);
    assign in_score = in_box(raster.hcount, raster.vcount, game_pkg::SCORE_X,
        game_pkg::SCORE_Y, game_pkg::N_DIGITS * game_pkg::DIGIT_SIZE, game_pkg::DIGIT_SIZE);
    assign digit = in_score ? score[3'(game_pkg::N_DIGITS - 1) - slot] : 4'd0;  // MSD left

    always_comb begin
        pixel = video_pkg::SKY_COLOR;
        if (!game_over) begin
            if (raster.vcount == game_pkg::GROUND_Y) begin
                pixel = video_pkg::GROUND_LINE_COLOR;
            end else if (raster.vcount > game_pkg::DIRT_Y) begin
                pixel = video_pkg::DEEP_DIRT_COLOR;
            end else if (raster.vcount > game_pkg::GROUND_Y) begin
                pixel = video_pkg::DIRT_COLOR;
            end

            if (in_box(raster.hcount, raster.vcount, player.x, player.y,
                       game_pkg::BOX_SIZE, game_pkg::BOX_SIZE)) begin
                if (player.ducking) begin
                    pixel = video_pkg::DINO_DUCK_COLOR;
                end else if (player.jumping) begin
                    pixel = video_pkg::DINO_JUMP_COLOR;
                end else begin
                    pixel = video_pkg::DINO_RUN_COLOR;
                end
            end

            if (in_box(raster.hcount, raster.vcount, obstacles.scac_x, game_pkg::GROUND_OBST_Y,
                       game_pkg::BOX_SIZE, game_pkg::BOX_SIZE)) begin
                pixel = video_pkg::CACTUS_COLOR;
            end
            if (in_box(raster.hcount, raster.vcount, obstacles.group_x, game_pkg::GROUND_OBST_Y,
                       game_pkg::GROUP_WIDTH, game_pkg::BOX_SIZE)) begin
                pixel = video_pkg::CACTUS_COLOR;
            end
            if (in_box(raster.hcount, raster.vcount, obstacles.lava_x, game_pkg::GROUND_OBST_Y,
                       game_pkg::BOX_SIZE, game_pkg::BOX_SIZE)) begin
                pixel = video_pkg::LAVA_COLOR;
            end
            if (in_box(raster.hcount, raster.vcount, obstacles.ptero_x, game_pkg::PTERO_Y,
                       game_pkg::BOX_SIZE, game_pkg::BOX_SIZE)) begin
                pixel = video_pkg::PTERO_COLOR;
            end

            if (in_score && DIGIT_FONT[digit][ry][3'd7 - cx]) begin
                pixel = video_pkg::DIGIT_COLOR;
            end
        end else if (in_box(raster.hcount, raster.vcount, game_pkg::BANNER_X,
                            game_pkg::BANNER_Y, game_pkg::BANNER_W, game_pkg::BOX_SIZE)) begin
            pixel = video_pkg::BANNER_COLOR;  // Replay banner
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            color <= video_pkg::SKY_COLOR;
        end else begin
            color <= pixel;
        end
    end

endmodule

// File: hw/dino_game_top.sv
// Runner game top level, connects the bus and VGA pins to the game blocks
`timescale 1ns/1ps

module dino_game_top #(
    parameter int TICK_CYCLES = 2_000_000
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             chipselect,
    input  logic             write,
    input  logic [8:0]       address,
    input  logic [31:0]      writedata,
    output logic [7:0]       vga_r,
    output logic [7:0]       vga_g,
    output logic [7:0]       vga_b,
    output logic             vga_clk,
    output logic             vga_hs,
    output logic             vga_vs,
    output logic             vga_blank_n,
    output logic             vga_sync_n,
    output logic             game_over,
    output game_pkg::score_t score
);

    video_pkg::raster_t   raster;
    video_pkg::rgb_t      color;
    game_pkg::player_t    player;
    game_pkg::obstacles_t obstacles;
    logic                 tick;
    logic                 restart;

    video_timing u_timing (.clk, .reset, .raster, .vga_clk, .vga_hs, .vga_vs,
                           .vga_blank_n, .vga_sync_n);

    game_control #(.TICK_CYCLES(TICK_CYCLES)) u_control (
        .clk, .reset, .chipselect, .write, .address, .writedata,
        .obstacles, .player, .tick, .restart, .game_over
    );

    obstacle_track u_obstacles (.clk, .reset, .tick, .restart, .obstacles);

    score_counter u_score (.clk, .reset, .tick, .restart, .score);

    pixel_renderer u_renderer (.clk, .reset, .game_over, .raster, .player, .obstacles,
                               .score, .color);

    assign vga_r = color.r;
    assign vga_g = color.g;
    assign vga_b = color.b;

endmodule

// File: verification/dino_game_tb.sv
// Self-checking testbench that run_sim.sh builds around the runner game top level
`timescale 1ns/1ps

module dino_game_tb;

    localparam int TICK_CYCLES    = 16;
    localparam int FRAME_CYCLES   = int'(video_pkg::H_TOTAL) * int'(video_pkg::V_TOTAL);
    localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 10_000;
    localparam int LAST_ROW       = 40;  // Rows 0 to 40 hold sky, score and dino
    localparam int BOX            = game_pkg::BOX_SIZE;

    logic             clk;
    logic             reset;
    logic             chipselect;
    logic             write;
    logic [8:0]       address;
    logic [31:0]      writedata;
    logic [7:0]       vga_r;
    logic [7:0]       vga_g;
    logic [7:0]       vga_b;
    logic             vga_clk;
    logic             vga_hs;
    logic             vga_vs;
    logic             vga_blank_n;
    logic             vga_sync_n;
    logic             game_over;
    game_pkg::score_t score;
    video_pkg::rgb_t  color;

    video_pkg::raster_t m_raster;
    video_pkg::raster_t prev_raster;  // Raster behind the registered color
    game_pkg::score_t   m_score;
    game_pkg::score_t   prev_score;
    int                 edge_count;
    int                 cycle_count = 0;
    int                 m_x;
    int                 m_y;
    logic               m_duck;
    logic               m_jump;
    logic               sync_on;
    logic               score_on;
    logic               render_on;
    logic               exp_hit;
    logic [4:0]         sync_exp;

    `include "digit_font.svh"

    dino_game_top #(.TICK_CYCLES(TICK_CYCLES)) UUT (
        .clk, .reset, .chipselect, .write, .address, .writedata,
        .vga_r, .vga_g, .vga_b, .vga_clk, .vga_hs, .vga_vs, .vga_blank_n, .vga_sync_n,
        .game_over, .score
    );

    assign color = {vga_r, vga_g, vga_b};

    always #20 clk = ~clk;

    function automatic video_pkg::raster_t raster_next(input video_pkg::raster_t r);
        video_pkg::raster_t n;
        n = r;
        if (int'(r.hcount) == int'(video_pkg::H_TOTAL) - 1) begin
            n.hcount = '0;
            n.vcount = (int'(r.vcount) == int'(video_pkg::V_TOTAL) - 1) ? '0 : r.vcount + 1'b1;
        end else begin
            n.hcount = r.hcount + 1'b1;
        end
        return n;
    endfunction

    // Expected {hs, vs, blank_n, sync_n, vga_clk}
    function automatic logic [4:0] sync_ref(input video_pkg::raster_t r);
        int h;
        int v;
        int hs_start;
        int vs_start;
        h = int'(r.hcount);
        v = int'(r.vcount);
        hs_start = int'(video_pkg::H_ACTIVE) + int'(video_pkg::H_FRONT);
        vs_start = int'(video_pkg::V_ACTIVE) + int'(video_pkg::V_FRONT);
        return {!(h >= hs_start && h < hs_start + int'(video_pkg::H_SYNC)),
                !(v >= vs_start && v < vs_start + int'(video_pkg::V_SYNC)),
                h < int'(video_pkg::H_ACTIVE) && v < int'(video_pkg::V_ACTIVE),
                1'b0,
                h % 2 == 1};
    endfunction

    // Decimal value plus one, modulo 100000
    function automatic game_pkg::score_t bcd_next(input game_pkg::score_t s);
        game_pkg::score_t r;
        int               value;
        value = 0;
        for (int i = game_pkg::N_DIGITS - 1; i >= 0; i--) begin
            value = value * 10 + int'(s[i]);
        end
        value = (value + 1) % 100000;
        for (int i = 0; i < game_pkg::N_DIGITS; i++) begin
            r[i]  = 4'(value % 10);
            value = value / 10;
        end
        return r;
    endfunction

    function automatic logic overlap(input int ax, ay, aw, ah, bx, by, bw, bh);
        return ax < bx + bw && bx < ax + aw && ay < by + bh && by < ay + ah;
    endfunction

    // Obstacles still at their reset positions
    function automatic logic hits_home_obstacles(input int x, y);
        return overlap(x, y, BOX, BOX, game_pkg::SCAC_X_INIT, game_pkg::GROUND_OBST_Y, BOX, BOX) ||
            overlap(x, y, BOX, BOX, game_pkg::GROUP_X_INIT, game_pkg::GROUND_OBST_Y,
                    game_pkg::GROUP_WIDTH, BOX) ||
            overlap(x, y, BOX, BOX, game_pkg::LAVA_X_INIT, game_pkg::GROUND_OBST_Y, BOX, BOX) ||
            overlap(x, y, BOX, BOX, game_pkg::PTERO_X_INIT, game_pkg::PTERO_Y, BOX, BOX);
    endfunction

    function automatic video_pkg::rgb_t pixel_ref(input video_pkg::raster_t r, input int dx, dy,
                                                  input logic duck, jump, over,
                                                  input game_pkg::score_t s);
        video_pkg::rgb_t c;
        int              px;
        int              py;
        int              col;
        px  = int'(r.hcount);
        py  = int'(r.vcount);
        col = px - int'(game_pkg::SCORE_X);
        c   = video_pkg::SKY_COLOR;
        if (over) begin
            if (overlap(px, py, 1, 1, game_pkg::BANNER_X, game_pkg::BANNER_Y,
                        game_pkg::BANNER_W, BOX)) begin
                c = video_pkg::BANNER_COLOR;
            end
        end else begin
            if (py == int'(game_pkg::GROUND_Y)) begin
                c = video_pkg::GROUND_LINE_COLOR;
            end else if (py > int'(game_pkg::DIRT_Y)) begin
                c = video_pkg::DEEP_DIRT_COLOR;
            end else if (py > int'(game_pkg::GROUND_Y)) begin
                c = video_pkg::DIRT_COLOR;
            end
            if (overlap(px, py, 1, 1, dx, dy, BOX, BOX)) begin
                c = duck ? video_pkg::DINO_DUCK_COLOR :
                    (jump ? video_pkg::DINO_JUMP_COLOR : video_pkg::DINO_RUN_COLOR);
            end
            if (col >= 0 && col < game_pkg::N_DIGITS * game_pkg::DIGIT_SIZE &&
                py >= int'(game_pkg::SCORE_Y) &&
                py < int'(game_pkg::SCORE_Y) + game_pkg::DIGIT_SIZE) begin
                // Leftmost slot shows the top digit and bit 7 is the left pixel
                if (DIGIT_FONT[s[game_pkg::N_DIGITS - 1 - col / game_pkg::DIGIT_SIZE]]
                        [py - int'(game_pkg::SCORE_Y)][7 - col % game_pkg::DIGIT_SIZE]) begin
                    c = video_pkg::DIGIT_COLOR;
                end
            end
        end
        return c;
    endfunction

    task automatic check_value(input logic [31:0] actual, expected, input string name);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        m_x    = int'(game_pkg::DINO_X_INIT);
        m_y    = int'(game_pkg::DINO_Y_INIT);
        m_duck = 1'b0;
        m_jump = 1'b0;
    endtask

    task automatic bus_write(input logic [8:0] addr, input logic [31:0] data);
        @(posedge clk);
        chipselect <= 1'b1;
        write      <= 1'b1;
        address    <= addr;
        writedata  <= data;
        @(posedge clk);  // Write lands on this edge
        chipselect <= 1'b0;
        write      <= 1'b0;
    endtask

    task automatic wait_raster(input int h, v);
        do @(negedge clk);
        while (int'(m_raster.hcount) != h || int'(m_raster.vcount) != v);
    endtask

    task automatic check_rows();
        render_on = 1'b1;
        wait_raster(0, LAST_ROW + 2);
        render_on = 1'b0;
    endtask

    // One pixel of the game-over screen
    task automatic pixel_at(input int h, v, input string name);
        do @(negedge clk);
        while (int'(prev_raster.hcount) != h || int'(prev_raster.vcount) != v);
        check_value(color, pixel_ref(prev_raster, m_x, m_y, m_duck, m_jump, 1'b1, prev_score),
                    name);
    endtask

    // Raster and score models stepped on the same edges as the DUT
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            m_raster    <= '0;
            prev_raster <= '0;
            m_score     <= '0;
            prev_score  <= '0;
            edge_count  <= 0;
        end else begin
            prev_raster <= m_raster;
            prev_score  <= m_score;
            m_raster    <= raster_next(m_raster);
            edge_count  <= edge_count + 1;
            if (edge_count != 0 && edge_count % TICK_CYCLES == 0) begin
                m_score <= bcd_next(m_score);  // Score follows the tick by one edge
            end
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (sync_on) begin
                sync_exp = sync_ref(m_raster);
                check_value(vga_hs, sync_exp[4], "vga_hs");
                check_value(vga_vs, sync_exp[3], "vga_vs");
                check_value(vga_blank_n, sync_exp[2], "vga_blank_n");
                check_value(vga_sync_n, sync_exp[1], "vga_sync_n");
                check_value(vga_clk, sync_exp[0], "vga_clk");
            end
            if (score_on) begin
                check_value(score, m_score, "score");
            end
            if (render_on && int'(prev_raster.vcount) <= LAST_ROW) begin
                check_value(color, pixel_ref(prev_raster, m_x, m_y, m_duck, m_jump, 1'b0,
                                             prev_score), "color");
            end
        end
    end

    always @(negedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "Simulation timed out");
        end
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b0;
        chipselect = 1'b0;
        write      = 1'b0;
        address    = '0;
        writedata  = '0;
        sync_on    = 1'b0;
        score_on   = 1'b0;
        render_on  = 1'b0;

        apply_reset();
        sync_on  = 1'b1;
        score_on = 1'b1;
        bus_write(game_pkg::ADDR_DINO_Y, 32'd0);  // Above every obstacle
        m_y = 0;
        wait_raster(0, 0);
        sync_on = 1'b0;

        check_rows();  // Running
        bus_write(game_pkg::ADDR_DUCK, 32'd1);
        m_duck = 1'b1;
        wait_raster(0, 0);
        check_rows();
        bus_write(game_pkg::ADDR_DUCK, 32'd0);
        bus_write(game_pkg::ADDR_JUMP, 32'd1);
        m_duck = 1'b0;
        m_jump = 1'b1;
        wait_raster(0, 0);
        check_rows();
        score_on = 1'b0;

        // Collision with the cactus before its first move
        apply_reset();
        bus_write(game_pkg::ADDR_DINO_Y, 32'd248);
        m_y = 248;
        bus_write(game_pkg::ADDR_DINO_X, 32'd1200);
        m_x = 1200;
        exp_hit = hits_home_obstacles(m_x, m_y);
        @(negedge clk);
        check_value(game_over, 1'b0, "game_over");
        @(negedge clk);
        check_value(game_over, exp_hit, "game_over");
        repeat (100) begin
            @(negedge clk);
            check_value(score, '0, "score");
        end

        pixel_at(game_pkg::BANNER_X, game_pkg::BANNER_Y, "color");
        pixel_at(m_x, m_y, "color");

        bus_write(game_pkg::ADDR_DINO_Y, 32'd0);
        m_y = 0;
        bus_write(game_pkg::ADDR_REPLAY, 32'd1);
        @(negedge clk);
        check_value(game_over, 1'b1, "game_over");
        @(negedge clk);
        check_value(game_over, 1'b0, "game_over");
        @(negedge clk);
        check_value(score, '0, "score");
        // Tick counter starts over on restart
        repeat (TICK_CYCLES) begin
            @(negedge clk);
            check_value(score, '0, "score");
        end
        @(negedge clk);
        check_value(score, bcd_next('0), "score");

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: dino_game_top.f
+incdir+hw
hw/video_pkg.sv
hw/game_pkg.sv
hw/video_timing.sv
hw/game_control.sv
hw/obstacle_track.sv
hw/score_counter.sv
hw/pixel_renderer.sv
hw/dino_game_top.sv
verification/dino_game_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the runner game testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing -Wno-fatal --top-module dino_game_tb \
    -f dino_game_top.f -o dino_game_sim > "$LOG" 2>&1 &&
    ./obj_dir/dino_game_sim >> "$LOG" 2>&1

grep -qx '>>> PASS' "$LOG" && echo "Simulation passed, see $LOG" && exit 0 ||
    { echo "Simulation failed, see $LOG"; exit 1; }
